//--- list.f
source/srcPkg.sv
source/regBusIf.sv
source/selectEncode.sv
source/registerFile.sv
source/aluUnit.sv
source/controlUnit.sv
source/srcCore.sv
test/tbChecker.sv
test/tbSrcCore.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tbSrcCore -o simSrcCore

./obj_dir/simSrcCore > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	exit 0
fi
exit 1

//--- source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit #(
	parameter int DATA_WIDTH = 32
) (
	input logic clock,
	input logic arstN,
	regBusIf.alu bus,
	input logic [DATA_WIDTH-1:0] bIn,
	input srcPkg::aluOpT op,
	input logic yIn,
	input logic zIn
);
	import srcPkg::*;

	logic [DATA_WIDTH-1:0] y;
	logic [DATA_WIDTH-1:0] z;
	logic [DATA_WIDTH-1:0] result;

	always_comb begin
		case (op)
			aluAdd: begin
				result = y + bIn;
			end
			aluSub: begin
				result = y - bIn;
			end
			aluAnd: begin
				result = y & bIn;
			end
			aluOr: begin
				result = y | bIn;
			end
			default: begin
				result = y + bIn;
			end
		endcase
	end

	// Y holds the first operand, Z the result until write-back
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			y <= '0;
			z <= '0;
		end else begin
			if (yIn) begin
				y <= bus.busData;
			end
			if (zIn) begin
				z <= result;
			end
		end
	end

	assign bus.zData = z;

	// the sequencer computes Z in the step right after loading Y
	assert property (@(posedge clock) disable iff (!arstN) yIn |=> zIn);

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
	parameter int DATA_WIDTH = 32
) (
	input logic clock,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [srcPkg::ADDR_WIDTH-1:0] paddr,
	input logic [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	regBusIf.ctrl bus,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rin,
	output logic rout,
	output logic baReq,
	output logic cOut,
	output logic yIn,
	output logic zIn,
	output logic zOut,
	output srcPkg::instrWordT instr,
	output srcPkg::aluOpT op,
	output logic useConst
);
	import srcPkg::*;

	localparam logic [1:0] stepT0 = 2'd0;
	localparam logic [1:0] stepT1 = 2'd1;
	localparam logic [1:0] stepT2 = 2'd2;

	instrWordT ir;
	instrWordT newInstr;
	instrWordT hostWord;
	logic busy;
	logic [1:0] step;
	logic access;
	logic isInstr;
	logic isStatus;
	logic isReg;
	logic [REG_ADDR_BITS-1:0] regIndex;
	logic newSupported;
	logic instrWait;
	logic issue;
	logic hostRead;
	logic hostWrite;

	function automatic logic isSupported(opcodeT code);
		case (code)
			opLdi, opAdd, opSub, opAnd, opOr, opAddi, opAndi, opOri: begin
				isSupported = 1'b1;
			end
			default: begin
				isSupported = 1'b0;
			end
		endcase
	endfunction

	assign access = psel && penable;
	assign isInstr = (paddr == addrInstr);
	assign isStatus = (paddr == addrStatus);
	assign isReg = (paddr[ADDR_WIDTH-1:REG_ADDR_BITS+2] ==
		addrRegBase[ADDR_WIDTH-1:REG_ADDR_BITS+2]) && (paddr[1:0] == 2'b00);
	assign regIndex = paddr[2 +: REG_ADDR_BITS];

	assign newInstr = pwdata;
	assign newSupported = isSupported(newInstr.r.opcode);

	// an instruction write holds off until the running one retires
	assign instrWait = access && pwrite && isInstr && busy;
	assign pready = !instrWait;
	assign pslverr = access && pready && (!(isInstr || isStatus || isReg) ||
		(pwrite && isInstr && !newSupported) || (pwrite && isReg && busy));

	assign issue = access && pwrite && isInstr && !busy && newSupported;
	assign hostWrite = access && pwrite && isReg && !busy;
	assign hostRead = access && !pwrite && isReg && !busy;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ir <= '0;
			busy <= 1'b0;
			step <= stepT0;
		end else if (issue) begin
			ir <= newInstr;
			busy <= 1'b1;
			step <= stepT0;
		end else if (busy) begin
			if (step == stepT2) begin
				busy <= 1'b0;
				step <= stepT0;
			end else begin
				step <= step + 2'd1;
			end
		end
	end

	// opcode decode for the ALU and the B operand source
	always_comb begin
		op = aluAdd;
		useConst = 1'b0;
		case (ir.r.opcode)
			opLdi, opAddi: begin
				useConst = 1'b1;
			end
			opSub: begin
				op = aluSub;
			end
			opAnd: begin
				op = aluAnd;
			end
			opAndi: begin
				op = aluAnd;
				useConst = 1'b1;
			end
			opOr: begin
				op = aluOr;
			end
			opOri: begin
				op = aluOr;
				useConst = 1'b1;
			end
			default: begin
				op = aluAdd;
			end
		endcase
	end

	// host accesses present the register index as ra
	always_comb begin
		hostWord = '0;
		hostWord.r.ra = regIndex;
	end

	assign instr = busy ? ir : hostWord;

	always_comb begin
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		rin = 1'b0;
		rout = 1'b0;
		baReq = 1'b0;
		cOut = 1'b0;
		yIn = 1'b0;
		zIn = 1'b0;
		zOut = 1'b0;
		if (busy) begin
			case (step)
				stepT0: begin
					grb = 1'b1;
					yIn = 1'b1;
					if (ir.r.opcode == opLdi) begin
						baReq = 1'b1;
					end else begin
						rout = 1'b1;
					end
				end
				stepT1: begin
					cOut = 1'b1;
					zIn = 1'b1;
					if (!useConst) begin
						grc = 1'b1;
						rout = 1'b1;
					end
				end
				stepT2: begin
					gra = 1'b1;
					rin = 1'b1;
					zOut = 1'b1;
				end
				default: begin
					zOut = 1'b0;
				end
			endcase
		end else if (hostRead || hostWrite) begin
			gra = 1'b1;
			rout = 1'b1;
		end
	end

	assign bus.hostSel = hostWrite;
	assign bus.hostData = pwdata;

	// register reads while busy return zero since the sequencer owns the bus
	always_comb begin
		prdata = '0;
		if (isStatus) begin
			prdata = DATA_WIDTH'(busy);
		end else if (isInstr) begin
			prdata = DATA_WIDTH'(ir);
		end else if (hostRead) begin
			prdata = bus.busData;
		end
	end

	// a held-off instruction write keeps its access phase until accepted
	assert property (@(posedge clock) disable iff (!arstN)
		instrWait |=> (access && pwrite && isInstr && $stable(pwdata)));

	// an accepted instruction retires three cycles later
	assert property (@(posedge clock) disable iff (!arstN) $rose(busy) |-> ##3 !busy);

endmodule

//--- source/regBusIf.sv
`timescale 1ns/1ps

interface regBusIf #(
	parameter int DATA_WIDTH = 32,
	parameter int REG_COUNT = 16
);

	// one-hot register enables from the select-encode block
	logic [REG_COUNT-1:0] rIn;
	logic [REG_COUNT-1:0] rOut;
	logic baOut;

	logic [DATA_WIDTH-1:0] busData;
	logic [DATA_WIDTH-1:0] zData;

	// host side of the register file
	logic [DATA_WIDTH-1:0] hostData;
	logic hostSel;

	modport encoder (output rIn, rOut, baOut);
	modport regs (input rIn, rOut, baOut, zData, hostData, hostSel, output busData);
	modport alu (input busData, output zData);
	modport ctrl (input busData, output hostData, hostSel);

endinterface

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
	parameter int DATA_WIDTH = 32,
	parameter int REG_COUNT = 16
) (
	input logic clock,
	input logic arstN,
	regBusIf.regs bus
);

	logic [DATA_WIDTH-1:0] regs [REG_COUNT];
	logic [DATA_WIDTH-1:0] readData;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				// host writes address their target through the read enable
				if (bus.hostSel && bus.rOut[i]) begin
					regs[i] <= bus.hostData;
				end else if (bus.rIn[i]) begin
					regs[i] <= bus.zData;
				end
			end
		end
	end

	// R0 reads as zero when used as a base address
	always_comb begin
		readData = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			if (bus.rOut[i] && !(bus.baOut && i == 0)) begin
				readData = readData | regs[i];
			end
		end
	end

	assign bus.busData = readData;

	// the sequencer never writes back during a host write
	assert property (@(posedge clock) disable iff (!arstN)
		!(bus.hostSel && (|bus.rIn)));

endmodule

//--- source/selectEncode.sv
`timescale 1ns/1ps

module selectEncode #(
	parameter int DATA_WIDTH = 32,
	parameter int REG_COUNT = 16
) (
	input srcPkg::instrWordT instr,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rin,
	input logic rout,
	input logic baReq,
	regBusIf.encoder bus,
	output logic [DATA_WIDTH-1:0] cse
);
	import srcPkg::*;

	logic [REG_ADDR_BITS-1:0] field;
	logic fieldValid;
	logic [REG_COUNT-1:0] decoded;

	// ra wins over rb, rb over rc
	always_comb begin
		field = instr.r.ra;
		fieldValid = 1'b1;
		if (gra) begin
			field = instr.r.ra;
		end else if (grb) begin
			field = instr.r.rb;
		end else if (grc) begin
			field = instr.r.rc;
		end else begin
			fieldValid = 1'b0;
		end
	end

	always_comb begin
		decoded = '0;
		if (fieldValid) begin
			decoded[field] = 1'b1;
		end
	end

	assign bus.rIn = rin ? decoded : '0;

	// a base-address read still selects the register, the file zeroes R0
	assign bus.rOut = (rout || baReq) ? decoded : '0;
	assign bus.baOut = baReq;

	// sign-extend the 19-bit constant to the full bus width
	assign cse = {{(DATA_WIDTH-CONST_WIDTH){instr.i.c[CONST_WIDTH-1]}}, instr.i.c};

endmodule

//--- source/srcCore.sv
`timescale 1ns/1ps

module srcCore #(
	parameter int DATA_WIDTH = 32,
	parameter int REG_COUNT = 16
) (
	input logic clock,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [srcPkg::ADDR_WIDTH-1:0] paddr,
	input logic [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import srcPkg::*;

	regBusIf #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT)) bus ();

	instrWordT instr;
	aluOpT op;
	logic gra;
	logic grb;
	logic grc;
	logic rin;
	logic rout;
	logic baReq;
	logic cOut;
	logic yIn;
	logic zIn;
	logic useConst;
	logic [DATA_WIDTH-1:0] cse;
	logic [DATA_WIDTH-1:0] bIn;

	// Z feeds the register file directly, so its bus strobe has no load here
	controlUnit #(.DATA_WIDTH(DATA_WIDTH)) uControl (
		.clock(clock),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.bus(bus.ctrl),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.baReq(baReq),
		.cOut(cOut),
		.yIn(yIn),
		.zIn(zIn),
		.zOut(),
		.instr(instr),
		.op(op),
		.useConst(useConst)
	);

	selectEncode #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT)) uEncode (
		.instr(instr),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.baReq(baReq),
		.bus(bus.encoder),
		.cse(cse)
	);

	registerFile #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT)) uRegs (
		.clock(clock),
		.arstN(arstN),
		.bus(bus.regs)
	);

	aluUnit #(.DATA_WIDTH(DATA_WIDTH)) uAlu (
		.clock(clock),
		.arstN(arstN),
		.bus(bus.alu),
		.bIn(bIn),
		.op(op),
		.yIn(yIn),
		.zIn(zIn)
	);

	// constant operand in the T1 slot of immediate instructions
	assign bIn = (cOut && useConst) ? cse : bus.busData;

endmodule

//--- source/srcPkg.sv
package srcPkg;

	// APB address decode width
	localparam int ADDR_WIDTH = 12;
	// width of the ra, rb and rc fields
	localparam int REG_ADDR_BITS = 4;
	localparam int CONST_WIDTH = 19;

	typedef enum logic [4:0] {
		opLdi = 5'd1,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opAddi = 5'd12,
		opAndi = 5'd13,
		opOri = 5'd14
	} opcodeT;

	typedef struct packed {
		opcodeT opcode;
		logic [REG_ADDR_BITS-1:0] ra;
		logic [REG_ADDR_BITS-1:0] rb;
		logic [REG_ADDR_BITS-1:0] rc;
		logic [CONST_WIDTH-REG_ADDR_BITS-1:0] unused;
	} rFormatT;

	typedef struct packed {
		opcodeT opcode;
		logic [REG_ADDR_BITS-1:0] ra;
		logic [REG_ADDR_BITS-1:0] rb;
		logic [CONST_WIDTH-1:0] c;
	} iFormatT;

	// one instruction word, two field layouts
	typedef union packed {
		rFormatT r;
		iFormatT i;
	} instrWordT;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr
	} aluOpT;

	// APB register map
	localparam logic [ADDR_WIDTH-1:0] addrInstr = 12'h000;
	localparam logic [ADDR_WIDTH-1:0] addrStatus = 12'h004;
	localparam logic [ADDR_WIDTH-1:0] addrRegBase = 12'h040;

endpackage

//--- test/srcPatterns.txt
// columns: kind addr wdata expected (hex), kind 0 ends the list
// kinds 1 write, 2 read+compare, 3 write with pslverr, 4 read with pslverr, 5 poll idle, 6 held-off instr write
1 040 DEAD0000 0
1 044 00000005 0
1 048 00000003 0
1 04C 0000F0F0 0
1 050 12345678 0
2 040 0 DEAD0000
2 044 0 00000005
2 048 0 00000003
2 04C 0 0000F0F0
2 050 0 12345678
1 000 1A890000 0
5 004 0 0
2 054 0 00000008
1 000 23108000 0
5 004 0 0
2 058 0 FFFFFFFE
1 000 2B9A0000 0
5 004 0 0
2 05C 0 00005070
1 000 341A0000 0
5 004 0 0
2 060 0 1234F6F8
1 000 648FFFFD 0
5 004 0 0
2 064 0 00000002
1 000 6D27FFF0 0
5 004 0 0
2 068 0 12345670
1 000 7597FF00 0
5 004 0 0
2 06C 0 FFFFFF03
1 000 0E012345 0
5 004 0 0
2 070 0 00012345
1 000 0E8FFFFF 0
5 004 0 0
2 074 0 00000004
4 008 0 0
3 100 FFFFFFFF 0
3 000 10800000 0
5 004 0 0
2 044 0 00000005
1 000 1F090000 0
3 044 00000BAD 0
5 004 0 0
2 044 0 00000005
2 078 0 00000008
1 000 6788000A 0
6 000 1F790000 0
5 004 0 0
2 07C 0 0000000F
2 078 0 00000012
2 004 0 00000000
0 0 0 0

//--- test/tbChecker.sv
`timescale 1ns/1ps

module tbChecker #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 12
) (
	input logic clock,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [ADDR_WIDTH-1:0] paddr,
	input logic [DATA_WIDTH-1:0] prdata,
	input logic pready,
	input logic pslverr,
	input logic [DATA_WIDTH-1:0] expData,
	input logic expErr,
	input logic checkData,
	output int errorCount,
	output int checkCount
);

	int errors;
	int checks;

	// a transfer completes on the edge where pready is high in the access phase
	always @(posedge clock) begin
		if (arstN && psel && penable && pready) begin
			checks = checks + 1;
			if (pslverr !== expErr) begin
				errors = errors + 1;
				$display("FAIL at time %0t: pslverr got %b expected %b (paddr %h)",
					$time, pslverr, expErr, paddr);
			end else if (checkData && !pwrite && (prdata !== expData)) begin
				errors = errors + 1;
				$display("FAIL at time %0t: prdata got %h expected %h (paddr %h)",
					$time, prdata, expData, paddr);
			end
		end
	end

	assign errorCount = errors;
	assign checkCount = checks;

endmodule

//--- test/tbSrcCore.sv
`timescale 1ns/1ps

module tbSrcCore;
	import srcPkg::*;

	localparam int DATA_WIDTH = 32;
	localparam int MAX_WORDS = 512;
	localparam int MAX_POLLS = 20;

	logic clock;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [DATA_WIDTH-1:0] pwdata;
	logic [DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;

	// expected values handed to the checker with each transfer
	logic [DATA_WIDTH-1:0] expData;
	logic expErr;
	logic checkData;

	logic [31:0] patterns [0:MAX_WORDS-1];
	int patternCount;
	logic loaded;
	int driverErrors;
	int checkErrors;
	int checkCount;

	srcCore #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(16)) UUT (
		.clock(clock),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	tbChecker #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) apbChecker (
		.clock(clock),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.expData(expData),
		.expErr(expErr),
		.checkData(checkData),
		.errorCount(checkErrors),
		.checkCount(checkCount)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// one APB transfer with setup and access phases and a count of wait states
	task automatic apbTransfer(input logic isWrite, input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] data, input logic [DATA_WIDTH-1:0] expValue,
		input logic errValue, input logic compare, output int waits,
		output logic [DATA_WIDTH-1:0] rdata);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= isWrite;
		paddr <= addr;
		pwdata <= data;
		expData <= expValue;
		expErr <= errValue;
		checkData <= compare;
		@(posedge clock);
		penable <= 1'b1;
		waits = 0;
		@(posedge clock);
		while (!pready) begin
			waits = waits + 1;
			@(posedge clock);
		end
		rdata = prdata;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// reads status until busy is clear
	task automatic pollIdle();
		int polls;
		int waits;
		logic [DATA_WIDTH-1:0] rdata;
		polls = 0;
		rdata = '1;
		while (rdata[0] && polls < MAX_POLLS) begin
			apbTransfer(1'b0, addrStatus, '0, '0, 1'b0, 1'b0, waits, rdata);
			polls = polls + 1;
		end
		if (rdata[0]) begin
			driverErrors = driverErrors + 1;
			$display("ERROR at time %0t: core still busy after %0d status polls",
				$time, MAX_POLLS);
		end
	endtask

	initial begin
		logic [8:0] base;
		int kind;
		int waits;
		logic [DATA_WIDTH-1:0] rdata;
		logic [ADDR_WIDTH-1:0] addr;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		expData = '0;
		expErr = 1'b0;
		checkData = 1'b0;
		arstN = 1'b0;
		loaded = 1'b0;
		driverErrors = 0;
		$readmemh("test/srcPatterns.txt", patterns);
		// the list ends with a record of kind 0
		patternCount = 0;
		base = 9'd0;
		while (patternCount < MAX_WORDS / 4 && patterns[base] != 32'd0) begin
			patternCount = patternCount + 1;
			base = 9'(patternCount * 4);
		end
		if (patternCount == 0) begin
			driverErrors = driverErrors + 1;
			$display("ERROR: no patterns read from test/srcPatterns.txt");
		end
		loaded = 1'b1;
		repeat (10) @(posedge clock);
		arstN <= 1'b1;
		@(posedge clock);
		for (int n = 0; n < patternCount; n++) begin
			base = 9'(n * 4);
			kind = int'(patterns[base]);
			addr = patterns[base + 9'd1][ADDR_WIDTH-1:0];
			case (kind)
				1: apbTransfer(1'b1, addr, patterns[base + 9'd2], '0, 1'b0, 1'b0, waits, rdata);
				2: apbTransfer(1'b0, addr, '0, patterns[base + 9'd3], 1'b0, 1'b1, waits, rdata);
				3: apbTransfer(1'b1, addr, patterns[base + 9'd2], '0, 1'b1, 1'b0, waits, rdata);
				4: apbTransfer(1'b0, addr, '0, '0, 1'b1, 1'b0, waits, rdata);
				5: pollIdle();
				6: begin
					apbTransfer(1'b1, addr, patterns[base + 9'd2], '0, 1'b0, 1'b0, waits, rdata);
					if (waits == 0) begin
						driverErrors = driverErrors + 1;
						$display("ERROR at time %0t: instruction write was not held off while busy",
							$time);
					end
				end
				default: begin
					driverErrors = driverErrors + 1;
					$display("ERROR: pattern %0d has unknown kind %0d", n, kind);
				end
			endcase
		end
		repeat (2) @(posedge clock);
		$display("done: %0d patterns, %0d transfers checked, %0d checker errors, %0d driver errors",
			patternCount, checkCount, checkErrors, driverErrors);
		if (driverErrors == 0 && checkErrors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog sized from the pattern count
	initial begin
		wait (loaded);
		repeat (patternCount * 50 + 20) @(posedge clock);
		$display("ERROR: watchdog expired after %0d cycles", patternCount * 50 + 20);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
